// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/core_pkg.sv
      - design/decoder.sv
      - design/regfile.sv
      - design/alu.sv
      - design/branch_unit.sv
      - design/core_ctrl.sv
      - design/rv_core.sv
  - target: test
    files:
      - testbench/tb_mem_responder.sv
      - testbench/tb_rv_core.sv

// File: design/alu.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module alu (
  input  core_pkg::decoded_t dec,
  output rv_isa_pkg::xlen_t  result
);

  logic [`SHAMT_W-1:0] shamt;
  logic                lt_signed;
  logic                lt_unsigned;

  assign shamt       = dec.opb[`SHAMT_W-1:0];
  assign lt_signed   = $signed(dec.opa) < $signed(dec.opb);
  assign lt_unsigned = dec.opa < dec.opb;

  always_comb begin
    case (dec.alu_op.funct3)
      rv_isa_pkg::F3_ADD_SUB: begin
        if (dec.alu_op.alt) begin
          result = dec.opa - dec.opb;
        end else begin
          result = dec.opa + dec.opb;  // also lui, auipc and link
        end
      end
      rv_isa_pkg::F3_SLL:  result = dec.opa << shamt;
      rv_isa_pkg::F3_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
      rv_isa_pkg::F3_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      rv_isa_pkg::F3_XOR:  result = dec.opa ^ dec.opb;
      rv_isa_pkg::F3_SRL_SRA: begin
        if (dec.alu_op.alt) begin
          result = $unsigned($signed(dec.opa) >>> shamt);
        end else begin
          result = dec.opa >> shamt;
        end
      end
      rv_isa_pkg::F3_OR:   result = dec.opa | dec.opb;
      rv_isa_pkg::F3_AND:  result = dec.opa & dec.opb;
      default:             result = '0;
    endcase
  end

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module branch_unit (
  input  core_pkg::decoded_t dec,
  input  rv_isa_pkg::xlen_t  pc,
  output rv_isa_pkg::xlen_t  next_pc
);

  logic              cond;
  logic              take;
  rv_isa_pkg::xlen_t target;

  always_comb begin
    case (dec.alu_op.funct3)
      rv_isa_pkg::F3_BEQ:  cond = (dec.opa == dec.opb);
      rv_isa_pkg::F3_BNE:  cond = (dec.opa != dec.opb);
      rv_isa_pkg::F3_BLT:  cond = ($signed(dec.opa) < $signed(dec.opb));
      rv_isa_pkg::F3_BGE:  cond = ($signed(dec.opa) >= $signed(dec.opb));
      rv_isa_pkg::F3_BLTU: cond = (dec.opa < dec.opb);
      rv_isa_pkg::F3_BGEU: cond = (dec.opa >= dec.opb);
      default:             cond = 1'b0;
    endcase
  end

  assign take = dec.is_jump || (dec.is_branch && cond);

  // bit 0 cleared as jalr requires
  assign target = (dec.tgt_base + dec.tgt_off) & ~rv_isa_pkg::xlen_t'(1);

  assign next_pc = take ? target : pc + `LINK_STEP;

endmodule

// File: design/core_ctrl.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 imem_req,
  output rv_isa_pkg::xlen_t    imem_addr,
  input  logic                 imem_ack,
  input  rv_isa_pkg::instr_t   imem_data,
  output logic                 dmem_req,
  output core_pkg::dmem_req_t  dmem_out,
  input  logic                 dmem_ack,
  output rv_isa_pkg::instr_t   instr,
  output rv_isa_pkg::xlen_t    pc,
  input  core_pkg::decoded_t   dec,
  input  rv_isa_pkg::xlen_t    alu_result,
  input  rv_isa_pkg::xlen_t    next_pc,
  output logic                 rf_we,
  output rv_isa_pkg::reg_idx_t rf_rd,
  output rv_isa_pkg::xlen_t    rf_wdata
);

  core_pkg::ctrl_state_e state;
  core_pkg::decoded_t    dec_q;
  rv_isa_pkg::xlen_t     result_q;
  rv_isa_pkg::xlen_t     next_pc_q;

  assign imem_addr = pc;  // stable through the whole fetch handshake

  // store payload comes from the latched decode, low address bits dropped
  assign dmem_out.addr = {dec_q.tgt_base[`XLEN-1:`WORD_OFFSET_W], {`WORD_OFFSET_W{1'b0}}};
  assign dmem_out.data = dec_q.opb;

  assign rf_we    = (state == core_pkg::WRITEBACK) && dec_q.writes_rd;
  assign rf_rd    = dec_q.rd;
  assign rf_wdata = result_q;

  // control state
  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= core_pkg::FETCH;
      pc       <= `RESET_PC;
      imem_req <= 1'b0;
      dmem_req <= 1'b0;
    end else begin
      case (state)
        core_pkg::FETCH: begin
          imem_req <= 1'b1;  // first cycle after reset raises it here
          if (imem_req && imem_ack) begin
            imem_req <= 1'b0;
            state    <= core_pkg::FETCH_DONE;
          end
        end
        core_pkg::FETCH_DONE: begin
          if (!imem_ack) state <= core_pkg::DECODE;  // wait for ack to fall
        end
        core_pkg::DECODE: begin
          state <= core_pkg::EXECUTE;
        end
        core_pkg::EXECUTE: begin
          if (dec_q.is_store) begin
            dmem_req <= 1'b1;
            state    <= core_pkg::STORE;
          end else begin
            state    <= core_pkg::WRITEBACK;
          end
        end
        core_pkg::STORE: begin
          if (dmem_ack) begin
            dmem_req <= 1'b0;
            state    <= core_pkg::STORE_DONE;
          end
        end
        core_pkg::STORE_DONE: begin
          if (!dmem_ack) state <= core_pkg::WRITEBACK;
        end
        core_pkg::WRITEBACK: begin
          pc       <= next_pc_q;
          imem_req <= 1'b1;  // next fetch starts right away
          state    <= core_pkg::FETCH;
        end
        default: begin
          state <= core_pkg::FETCH;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state == core_pkg::FETCH && imem_req && imem_ack) begin
      instr <= imem_data;
    end
    if (state == core_pkg::DECODE) begin
      dec_q <= dec;
    end
    // decoder output still stable here, instr and regs untouched since DECODE
    if (state == core_pkg::EXECUTE) begin
      result_q  <= alu_result;
      next_pc_q <= next_pc;
    end
  end

endmodule

// File: design/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// shift amount field, low bits of operand b
`define SHAMT_W 5

// byte offset bits inside a word, ignored on stores
`define WORD_OFFSET_W 2

// pc value out of reset
`define RESET_PC 32'h0000_0000

// sequential pc step and link offset
`define LINK_STEP 32'd4

`endif

// File: design/core_pkg.sv
package core_pkg;

  typedef struct packed {
    rv_isa_pkg::funct3_t funct3;
    logic                alt;     // sub / arithmetic right shift
  } alu_op_t;

  typedef struct packed {
    rv_isa_pkg::xlen_t    opa;        // alu operands
    rv_isa_pkg::xlen_t    opb;
    rv_isa_pkg::xlen_t    tgt_base;   // jump target = base + off
    rv_isa_pkg::xlen_t    tgt_off;
    rv_isa_pkg::reg_idx_t rd;
    alu_op_t              alu_op;
    logic                 writes_rd;
    logic                 is_jump;
    logic                 is_branch;
    logic                 is_store;
    logic                 illegal;
  } decoded_t;

  // store payload, held while dmem_req is high
  typedef struct packed {
    rv_isa_pkg::xlen_t addr;
    rv_isa_pkg::xlen_t data;
  } dmem_req_t;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_DONE,
    DECODE,
    EXECUTE,
    STORE,
    STORE_DONE,
    WRITEBACK
  } ctrl_state_e;

endpackage

// File: design/decoder.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decoder (
  input  rv_isa_pkg::instr_t   instr,
  input  rv_isa_pkg::xlen_t    pc,
  input  rv_isa_pkg::xlen_t    rs1_val,
  input  rv_isa_pkg::xlen_t    rs2_val,
  output rv_isa_pkg::reg_idx_t rs1_idx,
  output rv_isa_pkg::reg_idx_t rs2_idx,
  output core_pkg::decoded_t   dec
);

  rv_isa_pkg::xlen_t   imm_i;
  rv_isa_pkg::xlen_t   imm_s;
  rv_isa_pkg::xlen_t   imm_b;
  rv_isa_pkg::xlen_t   imm_u;
  rv_isa_pkg::xlen_t   imm_j;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::opcode_e opcode;

  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];
  assign funct3  = instr[14:12];
  assign opcode  = rv_isa_pkg::opcode_e'(instr[6:2]);

  // sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec               = '0;
    dec.tgt_base      = pc;
    dec.rd            = instr[11:7];
    dec.alu_op.funct3 = rv_isa_pkg::F3_ADD_SUB;  // plain add unless overridden
    case (opcode)
      rv_isa_pkg::LUI: begin
        dec.opa       = imm_u;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        dec.opa       = imm_u;
        dec.opb       = pc;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        dec.opa       = pc;           // link = pc + 4
        dec.opb       = `LINK_STEP;
        dec.tgt_off   = imm_j;
        dec.is_jump   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        dec.opa       = pc;
        dec.opb       = `LINK_STEP;
        dec.tgt_base  = rs1_val;
        dec.tgt_off   = imm_i;
        dec.is_jump   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::BRANCH: begin
        dec.opa           = rs1_val;  // compared by branch_unit
        dec.opb           = rs2_val;
        dec.tgt_off       = imm_b;
        dec.alu_op.funct3 = funct3;
        // 010 and 011 are not branch encodings
        dec.is_branch     = (funct3[2:1] != 2'b01);
        dec.illegal       = (funct3[2:1] == 2'b01);
      end
      rv_isa_pkg::OP_IMM: begin
        dec.opa           = rs1_val;
        dec.opb           = imm_i;
        dec.alu_op.funct3 = funct3;
        dec.alu_op.alt    = (funct3 == rv_isa_pkg::F3_SRL_SRA) && instr[30];  // srai only
        dec.writes_rd     = 1'b1;
      end
      rv_isa_pkg::OP: begin
        dec.opa           = rs1_val;
        dec.opb           = rs2_val;
        dec.alu_op.funct3 = funct3;
        dec.alu_op.alt    = instr[30];
        dec.writes_rd     = 1'b1;
      end
      rv_isa_pkg::STORE: begin
        dec.tgt_base = rs1_val + imm_s;  // effective address
        dec.opb      = rs2_val;          // store data
        dec.is_store = (funct3 == rv_isa_pkg::F3_SW);
        dec.illegal  = (funct3 != rv_isa_pkg::F3_SW);
      end
      default: begin
        dec.illegal = 1'b1;  // falls through to pc + 4
      end
    endcase
  end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1_idx,
  input  rv_isa_pkg::reg_idx_t rs2_idx,
  output rv_isa_pkg::xlen_t    rs1_val,
  output rv_isa_pkg::xlen_t    rs2_val,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::xlen_t    rd_val
);

  rv_isa_pkg::xlen_t regs [`REG_COUNT];

  // combinational read ports
  assign rs1_val = regs[rs1_idx];
  assign rs2_val = regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin  // x0 stays zero
      regs[rd] <= rd_val;
    end
  end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic                imem_req,
  output rv_isa_pkg::xlen_t   imem_addr,
  input  logic                imem_ack,
  input  rv_isa_pkg::instr_t  imem_data,
  output logic                dmem_req,
  output core_pkg::dmem_req_t dmem_out,
  input  logic                dmem_ack
);

  rv_isa_pkg::instr_t   instr;
  rv_isa_pkg::xlen_t    pc;
  rv_isa_pkg::reg_idx_t rs1_idx;
  rv_isa_pkg::reg_idx_t rs2_idx;
  rv_isa_pkg::xlen_t    rs1_val;
  rv_isa_pkg::xlen_t    rs2_val;
  core_pkg::decoded_t   dec;
  rv_isa_pkg::xlen_t    alu_result;
  rv_isa_pkg::xlen_t    next_pc;
  logic                 rf_we;
  rv_isa_pkg::reg_idx_t rf_rd;
  rv_isa_pkg::xlen_t    rf_wdata;

  decoder decoder0 (
    .instr   (instr),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .dec     (dec)
  );

  regfile regfile0 (
    .clk     (clk),
    .rst     (rst),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .we      (rf_we),
    .rd      (rf_rd),
    .rd_val  (rf_wdata)
  );

  alu alu0 (
    .dec    (dec),
    .result (alu_result)
  );

  branch_unit branch_unit0 (
    .dec     (dec),
    .pc      (pc),
    .next_pc (next_pc)
  );

  core_ctrl core_ctrl0 (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_out   (dmem_out),
    .dmem_ack   (dmem_ack),
    .instr      (instr),
    .pc         (pc),
    .dec        (dec),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .rf_we      (rf_we),
    .rf_rd      (rf_rd),
    .rf_wdata   (rf_wdata)
  );

endmodule

// File: design/rv_isa_pkg.sv
`include "core_defines.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] xlen_t;        // data or address word
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [31:0] instr_t;            // raw instruction word
  typedef logic [2:0] funct3_t;

  // instr[6:2], low two bits are always 2'b11
  typedef enum logic [4:0] {
    LUI    = 5'b01101,
    AUIPC  = 5'b00101,
    JAL    = 5'b11011,
    JALR   = 5'b11001,
    BRANCH = 5'b11000,
    OP_IMM = 5'b00100,
    OP     = 5'b01100,
    STORE  = 5'b01000
  } opcode_e;

  // arithmetic sub-operations
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct3_t F3_SW = 3'b010;     // only word stores supported

endpackage

// File: flist.f
+incdir+design
design/rv_isa_pkg.sv
design/core_pkg.sv
design/decoder.sv
design/regfile.sv
design/alu.sv
design/branch_unit.sv
design/core_ctrl.sv
design/rv_core.sv
testbench/tb_mem_responder.sv
testbench/tb_rv_core.sv

// File: testbench/tb_mem_responder.sv
`timescale 1ns/1ps

module tb_mem_responder (
  input  logic                clk,
  input  logic                rst,
  input  logic                imem_req,
  input  rv_isa_pkg::xlen_t   imem_addr,
  output logic                imem_ack,
  output rv_isa_pkg::instr_t  imem_data,
  input  logic                dmem_req,
  input  core_pkg::dmem_req_t dmem_out,
  output logic                dmem_ack
);

  logic [31:0] rom [8];          // program loaded by the testbench top
  logic [31:0] lfsr = 32'h872cb3c0;
  int          i_wait = -1;      // -1 means no delay drawn yet
  int          d_wait = -1;
  logic        i_rst;            // rst as seen at the clock edge
  logic        d_rst;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 3 cycles with one lfsr step per bit
  function automatic int draw_delay();
    int d;
    d = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      d = (d << 1) | lfsr[0];
    end
    return d;
  endfunction

  // past the program the core spins on jal x0, 0
  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    if (addr < 32) return rom[addr[4:2]];
    return 32'h0000_006f;
  endfunction

  initial begin
    imem_ack  = 1'b0;
    imem_data = '0;
    dmem_ack  = 1'b0;
  end

  always @(posedge clk) begin
    i_rst = rst;
    #1;
    if (!i_rst) begin
      imem_ack = 1'b0;
      i_wait   = -1;
    end else if (imem_ack) begin
      if (!imem_req) imem_ack = 1'b0;  // four-phase release
    end else if (imem_req) begin
      if (i_wait < 0) i_wait = draw_delay();
      if (i_wait == 0) begin
        imem_data = rom_word(imem_addr);
        imem_ack  = 1'b1;
        i_wait    = -1;
      end else begin
        i_wait--;
      end
    end
  end

  always @(posedge clk) begin
    d_rst = rst;
    #1;
    if (!d_rst) begin
      dmem_ack = 1'b0;
      d_wait   = -1;
    end else if (dmem_ack) begin
      if (!dmem_req) dmem_ack = 1'b0;
    end else if (dmem_req) begin
      if (d_wait < 0) d_wait = draw_delay();
      if (d_wait == 0) begin
        dmem_ack = 1'b1;
        d_wait   = -1;
      end else begin
        d_wait--;
      end
    end
  end

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int NT = 12;
  localparam logic [6:0] OPI = 7'h13;

  logic                clk;
  logic                rst;
  logic                imem_req;
  rv_isa_pkg::xlen_t   imem_addr;
  logic                imem_ack;
  rv_isa_pkg::instr_t  imem_data;
  logic                dmem_req;
  core_pkg::dmem_req_t dmem_out;
  logic                dmem_ack;

  logic [31:0] prog  [NT][8];
  logic [31:0] exp_f [NT][8];   // fetch addresses in order
  logic [31:0] exp_sa[NT][4];   // store addresses
  logic [31:0] exp_sd[NT][4];   // store data
  int          n_f   [NT];
  int          n_st  [NT];
  string       tname [NT];

  int cur;
  int fetch_idx;
  int store_idx;
  int errs;
  int pass_cnt;
  int fail_cnt;
  int cycles;
  int limit;
  bit running;

  rv_core dut0 (.*);

  tb_mem_responder mem0 (.*);

  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  // sw rs2, imm(rs1)
  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic new_row(int t, string nm);
    tname[t] = nm;
    n_f[t]   = 0;
    n_st[t]  = 0;
    for (int i = 0; i < 8; i++) prog[t][i] = 32'h0000_006f;
  endtask

  task automatic add_fetch(int t, logic [31:0] a);
    exp_f[t][n_f[t]] = a;
    n_f[t]++;
  endtask

  task automatic add_store(int t, logic [31:0] a, logic [31:0] d);
    exp_sa[t][n_st[t]] = a;
    exp_sd[t][n_st[t]] = d;
    n_st[t]++;
  endtask

  // x1 = -7 and x2 = 5 are the stored markers
  // a taken branch skips the x1 store
  task automatic make_branch(int t, string nm, logic [2:0] f3, logic [4:0] a1, logic [4:0] a2,
                             bit ta, logic [4:0] b1, logic [4:0] b2, bit tb);
    new_row(t, nm);
    prog[t][0] = enc_i(-7, 0, 0, 1, OPI);
    prog[t][1] = enc_i(5, 0, 0, 2, OPI);
    prog[t][2] = enc_b(8, a2, a1, f3);
    prog[t][3] = enc_s(0, 1, 0);
    prog[t][4] = enc_s(0, 2, 0);
    prog[t][5] = enc_b(8, b2, b1, f3);
    prog[t][6] = enc_s(4, 1, 0);
    prog[t][7] = enc_s(4, 2, 0);
    add_fetch(t, 0);
    add_fetch(t, 4);
    add_fetch(t, 8);
    if (!ta) begin
      add_fetch(t, 12);
      add_store(t, 0, 32'hffff_fff9);
    end
    add_fetch(t, 16);
    add_store(t, 0, 5);
    add_fetch(t, 20);
    if (!tb) begin
      add_fetch(t, 24);
      add_store(t, 4, 32'hffff_fff9);
    end
    add_fetch(t, 28);
    add_store(t, 4, 5);
  endtask

  task automatic arith_row(int t, string nm, logic [31:0] w2, logic [31:0] w4,
                           logic [31:0] w6);
    new_row(t, nm);
    prog[t][0] = enc_i(-7, 0, 0, 1, OPI);
    prog[t][1] = enc_i(3, 0, 0, 2, OPI);
    prog[t][2] = w2;
    prog[t][3] = enc_s(0, 3, 0);
    prog[t][4] = w4;
    prog[t][5] = enc_s(4, 4, 0);
    prog[t][6] = w6;
    prog[t][7] = enc_s(8, 5, 0);
    for (int i = 0; i < 8; i++) add_fetch(t, 4 * i);
  endtask

  task automatic build_table();
    arith_row(0, "add sub slt", enc_r(0, 2, 1, 0, 3), enc_r(7'h20, 2, 1, 0, 4),
              enc_r(0, 2, 1, 2, 5));
    add_store(0, 0, 32'hffff_fffc);
    add_store(0, 4, 32'hffff_fff6);
    add_store(0, 8, 1);
    arith_row(1, "sltu xor or", enc_r(0, 2, 1, 3, 3), enc_r(0, 2, 1, 4, 4),
              enc_r(0, 2, 1, 6, 5));
    add_store(1, 0, 0);
    add_store(1, 4, 32'hffff_fffa);
    add_store(1, 8, 32'hffff_fffb);
    arith_row(2, "and sll sra", enc_r(0, 2, 1, 7, 3), enc_r(0, 2, 1, 1, 4),
              enc_r(7'h20, 2, 1, 5, 5));
    add_store(2, 0, 1);
    add_store(2, 4, 32'hffff_ffc8);
    add_store(2, 8, 32'hffff_ffff);
    // lui at 16 and auipc at 24
    arith_row(3, "srl lui auipc", enc_r(0, 2, 1, 5, 3), {20'h12345, 5'd4, 7'h37},
              {20'h00001, 5'd5, 7'h17});
    add_store(3, 0, 32'h1fff_ffff);
    add_store(3, 4, 32'h1234_5000);
    add_store(3, 8, 32'h0000_1018);
    make_branch(4, "beq", 3'b000, 1, 0, 0, 0, 0, 1);
    make_branch(5, "bne", 3'b001, 1, 0, 1, 0, 0, 0);
    make_branch(6, "blt", 3'b100, 1, 0, 1, 0, 1, 0);
    make_branch(7, "bge", 3'b101, 1, 0, 0, 0, 1, 1);
    make_branch(8, "bltu", 3'b110, 1, 0, 0, 0, 1, 1);
    make_branch(9, "bgeu", 3'b111, 1, 0, 1, 0, 1, 0);
    // skipped slots would store to 0x40
    new_row(10, "jal jalr");
    prog[10][0] = enc_j(12, 1);
    prog[10][1] = enc_s(32'h40, 0, 0);
    prog[10][2] = enc_s(32'h40, 0, 0);
    prog[10][3] = enc_s(0, 1, 0);
    prog[10][4] = enc_i(28, 0, 0, 5, 7'h67);
    prog[10][5] = enc_s(32'h40, 0, 0);
    prog[10][6] = enc_s(32'h40, 0, 0);
    prog[10][7] = enc_s(4, 5, 0);
    add_fetch(10, 0);
    add_fetch(10, 12);
    add_fetch(10, 16);
    add_fetch(10, 28);
    add_store(10, 0, 4);
    add_store(10, 4, 20);
    new_row(11, "x0");
    prog[11][0] = enc_i(9, 0, 0, 0, OPI);
    prog[11][1] = enc_s(0, 0, 0);
    prog[11][2] = enc_i(9, 0, 0, 1, OPI);
    prog[11][3] = enc_s(4, 1, 0);
    for (int i = 0; i < 4; i++) add_fetch(11, 4 * i);
    add_store(11, 0, 0);
    add_store(11, 4, 9);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one sample per completed handshake
  always @(posedge clk) begin
    if (running && imem_req && imem_ack && fetch_idx < n_f[cur]) begin
      assert (imem_addr == exp_f[cur][fetch_idx]) else begin
        $display("CHECK FAILED t=%0t: fetch %0d addr %h expected %h", $time, fetch_idx,
                 imem_addr, exp_f[cur][fetch_idx]);
        errs++;
      end
      fetch_idx++;
    end
    if (running && dmem_req && dmem_ack && store_idx < n_st[cur]) begin
      assert (dmem_out.addr == exp_sa[cur][store_idx] &&
              dmem_out.data == exp_sd[cur][store_idx]) else begin
        $display("CHECK FAILED t=%0t: store %0d got %h <- %h expected %h <- %h", $time,
                 store_idx, dmem_out.addr, dmem_out.data, exp_sa[cur][store_idx],
                 exp_sd[cur][store_idx]);
        errs++;
      end
      store_idx++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run exceeded %0d cycles in test %0d", limit, cur);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b0;
    running = 1'b0;
    cur = 0;
    cycles = 0;
    limit = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    for (int t = 0; t < NT; t++) limit += 40 * n_f[t];
    for (int t = 0; t < NT; t++) begin
      @(posedge clk);
      #1 rst = 1'b0;
      running = 1'b0;
      cur = t;
      fetch_idx = 0;
      store_idx = 0;
      errs = 0;
      for (int i = 0; i < 8; i++) mem0.rom[i] = prog[t][i];
      repeat (10) @(posedge clk);
      #1 running = 1'b1;
      rst = 1'b1;
      wait (store_idx == n_st[t]);
      @(posedge clk);
      assert (fetch_idx == n_f[t]) else begin
        $display("CHECK FAILED t=%0t: %0d fetches seen, expected %0d", $time, fetch_idx,
                 n_f[t]);
        errs++;
      end
      if (errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("test %0d %s: %s (%0d errors)", t, tname[t], errs == 0 ? "ok" : "bad", errs);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
